// ==== play_pkg.sv ====
`default_nettype none

package play_pkg;

    // Chart memory geometry
    localparam int ADDR_W    = 8;
    localparam int SAVE_BASE = 128;
    localparam int CHART_MAX = 127;

    // Score widths and points per note
    localparam int SCORE_W  = 14;
    localparam int PTS_HIT  = 5;
    localparam int PTS_AUTO = 4;

    // One note, keys one-hot from C (bit 0) to B (bit 6)
    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] keys;
    } note_t;

    typedef struct packed {
        logic [6:0] pad;
        note_t      note;
    } note_word_t;

    // Word at a chart base holds the length, every other word a note
    typedef union packed {
        note_word_t  note_w;
        logic [15:0] length;
    } chart_word_u;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        chart_word_u       dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        chart_word_u dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== chart_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module chart_ram (
    input  logic              prog_clk,
    input  logic              rst,
    input  play_pkg::wb_req_t req,
    output play_pkg::wb_rsp_t rsp
);
    import play_pkg::*;

    chart_word_u mem [0:2**ADDR_W-1];
    chart_word_u rdata;
    logic        ack;

    // Single-cycle ack, never twice for the same request
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req.cyc && req.stb && !ack;
        end
    end

    always_ff @(posedge prog_clk) begin
        if (req.cyc && req.stb && !ack) begin
            if (req.we) begin
                mem[req.adr] <= req.dat;
            end
            rdata <= mem[req.adr];
        end
    end

    always_comb begin
        rsp.ack = ack;
        rsp.dat = rdata;
    end

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  logic              prog_clk,
    input  logic              rst,
    input  play_pkg::wb_req_t host_req,
    input  play_pkg::wb_req_t fetch_req,
    input  play_pkg::wb_req_t rec_req,
    output play_pkg::wb_rsp_t host_rsp,
    output play_pkg::wb_rsp_t fetch_rsp,
    output play_pkg::wb_rsp_t rec_rsp,
    output play_pkg::wb_req_t ram_req,
    input  play_pkg::wb_rsp_t ram_rsp
);
    // One-hot grant: host, fetcher, recorder
    logic [2:0] grant;
    logic       owner_cyc;

    assign owner_cyc = (grant[0] && host_req.cyc) ||
                       (grant[1] && fetch_req.cyc) ||
                       (grant[2] && rec_req.cyc);

    // New owner only picked when no cycle is open
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            grant <= 3'b000;
        end else if (!owner_cyc) begin
            if (host_req.cyc) begin
                grant <= 3'b001;
            end else if (fetch_req.cyc) begin
                grant <= 3'b010;
            end else if (rec_req.cyc) begin
                grant <= 3'b100;
            end else begin
                grant <= 3'b000;
            end
        end
    end

    always_comb begin
        ram_req = '0;
        if (grant[0]) begin
            ram_req = host_req;
        end else if (grant[1]) begin
            ram_req = fetch_req;
        end else if (grant[2]) begin
            ram_req = rec_req;
        end
    end

    // Read data fans out, ack goes to the owner only
    always_comb begin
        host_rsp      = ram_rsp;
        fetch_rsp     = ram_rsp;
        rec_rsp       = ram_rsp;
        host_rsp.ack  = ram_rsp.ack && grant[0];
        fetch_rsp.ack = ram_rsp.ack && grant[1];
        rec_rsp.ack   = ram_rsp.ack && grant[2];
    end

endmodule

`default_nettype wire

// ==== play_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module play_sequencer #(
    parameter int COUNT_CYCLES = 20,
    parameter int STEP_CYCLES  = 32
) (
    input  logic       prog_clk,
    input  logic       rst,
    input  logic       start,
    input  logic       ready,
    input  logic       chart_done,
    input  logic       saved,
    output logic       busy,
    output logic       load,
    output logic       step,
    output logic       done,
    output logic [1:0] count_phase
);
    localparam int CNT_TOP = (COUNT_CYCLES > STEP_CYCLES) ? COUNT_CYCLES : STEP_CYCLES;
    localparam int CNT_W   = $clog2(CNT_TOP + 1);

    typedef enum logic [2:0] {S_IDLE, S_COUNT, S_LOAD, S_PLAY, S_FINISH} state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state       <= S_IDLE;
            cnt         <= '0;
            busy        <= 1'b0;
            load        <= 1'b0;
            step        <= 1'b0;
            done        <= 1'b0;
            count_phase <= 2'd3;
        end else begin
            load <= 1'b0;
            step <= 1'b0;
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        busy        <= 1'b1;
                        cnt         <= '0;
                        count_phase <= 2'd3;
                        state       <= S_COUNT;
                    end
                end
                S_COUNT: begin
                    if (cnt == CNT_W'(COUNT_CYCLES - 1)) begin
                        cnt <= '0;
                        if (count_phase == 2'd0) begin
                            load  <= 1'b1;
                            state <= S_LOAD;
                        end else begin
                            count_phase <= count_phase - 2'd1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_LOAD: begin
                    // Ready from the last play is still up while load is high
                    if (!load && ready) begin
                        cnt   <= '0;
                        state <= S_PLAY;
                    end
                end
                S_PLAY: begin
                    if (chart_done) begin
                        state <= S_FINISH;
                    end else if (cnt == CNT_W'(STEP_CYCLES - 1)) begin
                        cnt  <= '0;
                        step <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_FINISH: begin
                    if (saved) begin
                        busy        <= 1'b0;
                        done        <= 1'b1;
                        count_phase <= 2'd3;
                        state       <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== note_fetcher.sv ====
`timescale 1ns/100ps
`default_nettype none

module note_fetcher (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              load,
    input  logic              step,
    output play_pkg::wb_req_t bus,
    input  play_pkg::wb_rsp_t bus_rsp,
    output logic              ready,
    output logic              chart_done,
    output logic [7:0]        note_index,
    output play_pkg::note_t   cur_note
);
    import play_pkg::*;

    typedef enum logic [1:0] {F_IDLE, F_LEN, F_NOTE} fstate_t;

    fstate_t           state;
    logic              cyc;
    logic [ADDR_W-1:0] adr;
    logic [ADDR_W-1:0] length;
    logic [7:0]        next_index;

    assign next_index = note_index + 8'd1;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state      <= F_IDLE;
            cyc        <= 1'b0;
            ready      <= 1'b0;
            chart_done <= 1'b0;
            note_index <= '0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (load) begin
                        ready      <= 1'b0;
                        chart_done <= 1'b0;
                        note_index <= '0;
                        cyc        <= 1'b1;
                        state      <= F_LEN;
                    end else if (step && ready && !chart_done) begin
                        note_index <= next_index;
                        if (next_index == length) begin
                            chart_done <= 1'b1;
                        end else begin
                            cyc   <= 1'b1;
                            state <= F_NOTE;
                        end
                    end
                end
                F_LEN: begin
                    if (bus_rsp.ack) begin
                        cyc <= 1'b0;
                        if (bus_rsp.dat.length == 16'd0) begin
                            ready      <= 1'b1;
                            chart_done <= 1'b1;
                            state      <= F_IDLE;
                        end else begin
                            state <= F_NOTE;
                        end
                    end
                end
                F_NOTE: begin
                    // Raise again after the length read has closed
                    if (!cyc) begin
                        cyc <= 1'b1;
                    end else if (bus_rsp.ack) begin
                        cyc   <= 1'b0;
                        ready <= 1'b1;
                        state <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // Length clamp, address and note payload
    always_ff @(posedge prog_clk) begin
        if (state == F_IDLE && load) begin
            adr <= '0;
        end else if (state == F_IDLE && step) begin
            adr <= next_index + 8'd1;
        end else if (state == F_LEN && bus_rsp.ack) begin
            adr <= ADDR_W'(1);
            if (bus_rsp.dat.length > 16'(CHART_MAX)) begin
                length <= ADDR_W'(CHART_MAX);
            end else begin
                length <= bus_rsp.dat.length[ADDR_W-1:0];
            end
        end
        if (state == F_NOTE && cyc && bus_rsp.ack) begin
            cur_note <= bus_rsp.dat.note_w.note;
        end
    end

    always_comb begin
        bus     = '0;
        bus.cyc = cyc;
        bus.stb = cyc;
        bus.adr = adr;
    end

endmodule

`default_nettype wire

// ==== play_recorder.sv ====
`timescale 1ns/100ps
`default_nettype none

module play_recorder (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              step,
    input  logic              chart_done,
    input  play_pkg::note_t   user_note,
    output play_pkg::wb_req_t bus,
    input  play_pkg::wb_rsp_t bus_rsp,
    output logic              saved
);
    import play_pkg::*;

    typedef enum logic [1:0] {R_IDLE, R_NOTE, R_HDR} rstate_t;

    rstate_t           state;
    logic              cyc;
    logic              hdr_done;
    logic [ADDR_W-1:0] count;
    logic [ADDR_W-1:0] adr;
    chart_word_u       wdat;
    chart_word_u       user_word;
    logic              take_note;

    always_comb begin
        user_word             = '0;
        user_word.note_w.note = user_note;
    end

    // Notes past the chart limit are dropped
    assign take_note = (state == R_IDLE) && step && (count != ADDR_W'(CHART_MAX));

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state    <= R_IDLE;
            cyc      <= 1'b0;
            hdr_done <= 1'b0;
            count    <= '0;
            saved    <= 1'b0;
        end else begin
            saved <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (!chart_done) begin
                        hdr_done <= 1'b0;
                    end
                    if (take_note) begin
                        cyc   <= 1'b1;
                        state <= R_NOTE;
                    end else if (chart_done && !hdr_done) begin
                        cyc   <= 1'b1;
                        state <= R_HDR;
                    end
                end
                R_NOTE: begin
                    if (bus_rsp.ack) begin
                        cyc   <= 1'b0;
                        count <= count + 1'b1;
                        state <= R_IDLE;
                    end
                end
                R_HDR: begin
                    if (bus_rsp.ack) begin
                        cyc      <= 1'b0;
                        saved    <= 1'b1;
                        hdr_done <= 1'b1;
                        count    <= '0;
                        state    <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge prog_clk) begin
        if (take_note) begin
            adr  <= ADDR_W'(SAVE_BASE + 1) + count;
            wdat <= user_word;
        end else if (state == R_IDLE) begin
            // Header goes to the saved chart's base
            adr         <= ADDR_W'(SAVE_BASE);
            wdat.length <= 16'(count);
        end
    end

    always_comb begin
        bus     = '0;
        bus.cyc = cyc;
        bus.stb = cyc;
        bus.we  = 1'b1;
        bus.adr = adr;
        bus.dat = wdat;
    end

endmodule

`default_nettype wire

// ==== note_judge.sv ====
`timescale 1ns/100ps
`default_nettype none

module note_judge (
    input  logic                         prog_clk,
    input  logic                         rst,
    input  logic                         step,
    input  logic                         auto_play,
    input  play_pkg::note_t              cur_note,
    input  play_pkg::note_t              user_note,
    output play_pkg::note_t              play_note,
    output logic [7:0]                   led,
    output logic [play_pkg::SCORE_W-1:0] score,
    output logic [play_pkg::SCORE_W-1:0] max_score
);
    import play_pkg::*;

    note_t      next_note;
    logic [7:0] next_led;

    assign next_note = auto_play ? cur_note : user_note;

    // C on the leftmost LED, octave shift on led[0]
    always_comb begin
        next_led[0] = next_note.oct_down || next_note.oct_up;
        for (int i = 0; i < 7; i++) begin
            next_led[7 - i] = next_note.keys[i];
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            play_note <= '0;
            led       <= '0;
            score     <= '0;
            max_score <= '0;
        end else if (step) begin
            play_note <= next_note;
            led       <= next_led;
            // Rests earn nothing
            if (cur_note.keys != 7'd0) begin
                max_score <= max_score + SCORE_W'(PTS_HIT);
                if (auto_play) begin
                    score <= score + SCORE_W'(PTS_AUTO);
                end else if (user_note == cur_note) begin
                    score <= score + SCORE_W'(PTS_HIT);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== play_chart.sv ====
`timescale 1ns/100ps
`default_nettype none

module play_chart #(
    parameter int COUNT_CYCLES = 20,
    parameter int STEP_CYCLES  = 32
) (
    input  logic                         prog_clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         auto_play,
    input  play_pkg::note_t              user_note,
    input  play_pkg::wb_req_t            host_req,
    output play_pkg::wb_rsp_t            host_rsp,
    output logic                         busy,
    output logic                         done,
    output logic [1:0]                   count_phase,
    output logic [7:0]                   note_index,
    output play_pkg::note_t              play_note,
    output logic [7:0]                   led,
    output logic [play_pkg::SCORE_W-1:0] score,
    output logic [play_pkg::SCORE_W-1:0] max_score
);
    import play_pkg::*;

    wb_req_t fetch_req;
    wb_req_t rec_req;
    wb_req_t ram_req;
    wb_rsp_t fetch_rsp;
    wb_rsp_t rec_rsp;
    wb_rsp_t ram_rsp;
    note_t   cur_note;
    logic    load;
    logic    step;
    logic    ready;
    logic    chart_done;
    logic    saved;

    play_sequencer #(
        .COUNT_CYCLES(COUNT_CYCLES),
        .STEP_CYCLES (STEP_CYCLES)
    ) u_seq (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .start      (start),
        .ready      (ready),
        .chart_done (chart_done),
        .saved      (saved),
        .busy       (busy),
        .load       (load),
        .step       (step),
        .done       (done),
        .count_phase(count_phase)
    );

    note_fetcher u_fetch (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .bus       (fetch_req),
        .bus_rsp   (fetch_rsp),
        .ready     (ready),
        .chart_done(chart_done),
        .note_index(note_index),
        .cur_note  (cur_note)
    );

    play_recorder u_rec (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .step      (step),
        .chart_done(chart_done),
        .user_note (user_note),
        .bus       (rec_req),
        .bus_rsp   (rec_rsp),
        .saved     (saved)
    );

    note_judge u_judge (
        .prog_clk (prog_clk),
        .rst      (rst),
        .step     (step),
        .auto_play(auto_play),
        .cur_note (cur_note),
        .user_note(user_note),
        .play_note(play_note),
        .led      (led),
        .score    (score),
        .max_score(max_score)
    );

    bus_arbiter u_arb (
        .prog_clk (prog_clk),
        .rst      (rst),
        .host_req (host_req),
        .fetch_req(fetch_req),
        .rec_req  (rec_req),
        .host_rsp (host_rsp),
        .fetch_rsp(fetch_rsp),
        .rec_rsp  (rec_rsp),
        .ram_req  (ram_req),
        .ram_rsp  (ram_rsp)
    );

    chart_ram u_ram (
        .prog_clk(prog_clk),
        .rst     (rst),
        .req     (ram_req),
        .rsp     (ram_rsp)
    );

endmodule

`default_nettype wire

// ==== tb_play_chart.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_play_chart;
    import play_pkg::*;

    localparam int COUNT_CYCLES = 20;
    localparam int STEP_CYCLES  = 32;
    localparam int BUS_TIMEOUT  = 50;
    localparam int PLAY_TIMEOUT = 5000;
    localparam int HIT_POINTS   = 5;
    localparam int AUTO_POINTS  = 4;

    logic               prog_clk = 1'b0;
    logic               rst;
    logic               start;
    logic               auto_play;
    note_t              user_note;
    wb_req_t            host_req;
    wb_rsp_t            host_rsp;
    logic               busy;
    logic               done;
    logic [1:0]         count_phase;
    logic [7:0]         note_index;
    note_t              play_note;
    logic [7:0]         led;
    logic [SCORE_W-1:0] score;
    logic [SCORE_W-1:0] max_score;

    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] seed;
    note_t       chart  [0:CHART_MAX-1];
    note_t       driven [0:CHART_MAX-1];

    play_chart #(
        .COUNT_CYCLES(COUNT_CYCLES),
        .STEP_CYCLES (STEP_CYCLES)
    ) DUT (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .start      (start),
        .auto_play  (auto_play),
        .user_note  (user_note),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .busy       (busy),
        .done       (done),
        .count_phase(count_phase),
        .note_index (note_index),
        .play_note  (play_note),
        .led        (led),
        .score      (score),
        .max_score  (max_score)
    );

    always #5 prog_clk = ~prog_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // C lights the leftmost LED, any octave shift lights led[0]
    function automatic logic [7:0] expected_led(input note_t n);
        return {n.keys[0], n.keys[1], n.keys[2], n.keys[3],
                n.keys[4], n.keys[5], n.keys[6], n.oct_down | n.oct_up};
    endfunction

    // Always differs from the chart note, rests included
    function automatic note_t wrong_note(input note_t n);
        note_t w;
        w = n;
        w.keys = (n.keys == 7'd0) ? 7'b0000001 : {n.keys[5:0], n.keys[6]};
        return w;
    endfunction

    function automatic chart_word_u note_word(input note_t n);
        chart_word_u w;
        w = '0;
        w.note_w.note = n;
        return w;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [15:0] expected, input logic [15:0] actual);
        $display("[ERROR] %s: %s expected %h actual %h", name, what, expected, actual);
        errors++;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(posedge prog_clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] adr, input chart_word_u dat);
        int cycles;
        host_req     = '0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = 1'b1;
        host_req.adr = adr;
        host_req.dat = dat;
        cycles = 0;
        do begin
            @(posedge prog_clk);
            #1;
            cycles++;
        end while (!host_rsp.ack && cycles < BUS_TIMEOUT);
        if (!host_rsp.ack) begin
            $display("Timeout: host write to address %0d was never acknowledged", adr);
            timeouts++;
        end
        host_req = '0;
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] adr, output chart_word_u dat);
        int cycles;
        host_req     = '0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.adr = adr;
        cycles = 0;
        do begin
            @(posedge prog_clk);
            #1;
            cycles++;
        end while (!host_rsp.ack && cycles < BUS_TIMEOUT);
        if (!host_rsp.ack) begin
            $display("Timeout: host read from address %0d was never acknowledged", adr);
            timeouts++;
        end
        dat      = host_rsp.dat;
        host_req = '0;
    endtask

    // One random key or a rest, plus at most one octave bit
    task automatic make_random_chart(input int len);
        int k;
        for (int i = 0; i < len; i++) begin
            seed = xorshift32(seed);
            k = seed % 8;
            chart[i] = '0;
            if (k < 7) begin
                chart[i].keys = 7'b0000001 << k;
            end
            chart[i].oct_down = (seed[9:8] == 2'd1);
            chart[i].oct_up   = (seed[9:8] == 2'd2);
        end
    endtask

    task automatic load_chart(input int len);
        chart_word_u w;
        w        = '0;
        w.length = 16'(len);
        host_write('0, w);
        for (int i = 0; i < len; i++) begin
            host_write(ADDR_W'(i + 1), note_word(chart[i]));
        end
    endtask

    task automatic run_play(input string name, input int len, input logic auto_mode,
                            input logic wrong_keys);
        int          cycles;
        int          exp_score;
        int          exp_max;
        logic [1:0]  phase;
        logic [7:0]  last_index;
        logic        got_done;
        note_t       played;
        chart_word_u w;
        auto_play = auto_mode;
        start     = 1'b1;
        @(posedge prog_clk);
        #1;
        start = 1'b0;
        if (busy !== 1'b1) begin
            report_mismatch(name, "busy after start", 16'd1, 16'(busy));
        end
        phase      = 2'd3;
        last_index = note_index;
        got_done   = 1'b0;
        cycles     = 0;
        while (!got_done && cycles < PLAY_TIMEOUT) begin
            // Player holds the note that the next step will judge
            if (note_index < len) begin
                user_note = wrong_keys ? wrong_note(chart[note_index]) : chart[note_index];
                driven[note_index] = user_note;
            end
            @(posedge prog_clk);
            #1;
            cycles++;
            if (busy && count_phase !== phase) begin
                if (count_phase !== phase - 2'd1) begin
                    report_mismatch(name, "count_phase order", 16'(phase - 2'd1),
                                    16'(count_phase));
                end
                phase = count_phase;
            end
            if (note_index !== last_index && note_index != 8'd0) begin
                // Each step plays the note of the step that just ended
                played = auto_mode ? chart[note_index - 1] : driven[note_index - 1];
                if (play_note !== played) begin
                    report_mismatch(name, "play_note", 16'(played), 16'(play_note));
                end
                if (led !== expected_led(played)) begin
                    report_mismatch(name, "led", 16'(expected_led(played)), 16'(led));
                end
            end
            last_index = note_index;
            got_done   = done;
        end
        if (!got_done) begin
            $display("Timeout: %s never signalled done", name);
            timeouts++;
            return;
        end
        if (phase !== 2'd0) begin
            report_mismatch(name, "last countdown phase", 16'd0, 16'(phase));
        end
        if (busy !== 1'b0) begin
            report_mismatch(name, "busy at done", 16'd0, 16'(busy));
        end
        if (note_index !== 8'(len)) begin
            report_mismatch(name, "note_index at done", 16'(len), 16'(note_index));
        end
        exp_score = 0;
        exp_max   = 0;
        for (int i = 0; i < len; i++) begin
            if (chart[i].keys != 7'd0) begin
                exp_max += HIT_POINTS;
                if (auto_mode) begin
                    exp_score += AUTO_POINTS;
                end else if (driven[i] == chart[i]) begin
                    exp_score += HIT_POINTS;
                end
            end
        end
        if (score !== SCORE_W'(exp_score)) begin
            report_mismatch(name, "score", 16'(exp_score), 16'(score));
        end
        if (max_score !== SCORE_W'(exp_max)) begin
            report_mismatch(name, "max_score", 16'(exp_max), 16'(max_score));
        end
        // Saved chart holds the player's notes behind a length header
        host_read(ADDR_W'(SAVE_BASE), w);
        if (w.length !== 16'(len)) begin
            report_mismatch(name, "saved length", 16'(len), w.length);
        end
        for (int i = 0; i < len; i++) begin
            host_read(ADDR_W'(SAVE_BASE + 1 + i), w);
            if (w !== note_word(driven[i])) begin
                report_mismatch(name, $sformatf("saved note %0d", i), note_word(driven[i]), w);
            end
        end
    endtask

    task automatic check_reset_state();
        if (busy !== 1'b0 || done !== 1'b0) begin
            report_mismatch("reset_state", "busy and done", 16'd0, 16'({busy, done}));
        end
        if (play_note !== '0 || led !== 8'd0) begin
            report_mismatch("reset_state", "play_note and led", 16'd0, 16'({play_note, led}));
        end
        if (score !== '0 || max_score !== '0) begin
            report_mismatch("reset_state", "score", 16'd0, 16'(score | max_score));
        end
        if (count_phase !== 2'd3) begin
            report_mismatch("reset_state", "count_phase", 16'd3, 16'(count_phase));
        end
    endtask

    task automatic check_host_access();
        logic [ADDR_W-1:0] adr;
        chart_word_u       w;
        chart_word_u       r;
        // Stride walks both chart halves and lands on SAVE_BASE
        for (int i = 0; i < 7; i++) begin
            adr      = ADDR_W'(i * 37 + 91);
            w.length = {adr ^ 8'h5a, ~adr};
            host_write(adr, w);
        end
        for (int i = 0; i < 7; i++) begin
            adr      = ADDR_W'(i * 37 + 91);
            w.length = {adr ^ 8'h5a, ~adr};
            host_read(adr, r);
            if (r !== w) begin
                report_mismatch("host_access", $sformatf("word at %0d", adr), w, r);
            end
        end
    endtask

    task automatic check_play(input string name, input int len, input logic auto_mode,
                              input logic wrong_keys);
        apply_reset();
        make_random_chart(len);
        load_chart(len);
        run_play(name, len, auto_mode, wrong_keys);
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        auto_play = 1'b0;
        user_note = '0;
        host_req  = '0;
        seed      = 32'h2137;
        apply_reset();
        check_reset_state();
        check_host_access();
        check_play("auto_play", 12, 1'b1, 1'b0);
        check_play("user_match", 12, 1'b0, 1'b0);
        if (score !== max_score) begin
            report_mismatch("user_match", "score against max_score", 16'(max_score), 16'(score));
        end
        check_play("user_wrong", 12, 1'b0, 1'b1);
        if (score !== '0) begin
            report_mismatch("user_wrong", "score", 16'd0, 16'(score));
        end
        check_play("empty_chart", 0, 1'b0, 1'b0);
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
play_pkg.sv
chart_ram.sv
bus_arbiter.sv
play_sequencer.sv
note_fetcher.sv
play_recorder.sv
note_judge.sv
play_chart.sv
tb_play_chart.sv

// ==== Bender.yml ====
package:
  name: play_chart

sources:
  - play_pkg.sv
  - chart_ram.sv
  - bus_arbiter.sv
  - play_sequencer.sv
  - note_fetcher.sv
  - play_recorder.sv
  - note_judge.sv
  - play_chart.sv
  - target: simulation
    files:
      - tb_play_chart.sv
